/* nocArb_consts.svh */
`ifndef NOC_ARB_CONSTS_SVH
`define NOC_ARB_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// router output-port allocation constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// input ports in the order L N E W S
`define NOC_PORTS 5

// flit payload width
`define NOC_FLIT_W 32

// packet length in clock periods
`define NOC_LEN_W 12

// flit kind field width
`define NOC_ID_W 3

// kind code carried by the first flit of a packet
`define NOC_HEAD_ID 3'd1

`endif

/* nocArbPkg.sv */
`include "nocArb_consts.svh"

package nocArbPkg;

  // one-hot so that grant is a direct slice of the state register
  typedef enum logic [5:0]
  {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbState;

  // only HEAD matters to the allocator, the rest ride along
  typedef enum logic [`NOC_ID_W-1:0]
  {
    NONE = 3'd0,
    HEAD = `NOC_HEAD_ID,
    BODY = 3'd2,
    TAIL = 3'd3
  } flitKind;

endpackage

/* packetTimer.sv */
`include "nocArb_consts.svh"

module packetTimer
(
  input  logic                   clk,
  input  logic                   rst,
  input  nocArbPkg::flitKind     flitId,
  input  logic [`NOC_LEN_W-1:0]  length,
  input  logic                   run,
  output logic                   timesUp
);

  logic [`NOC_LEN_W-1:0] limit;   // hold budget of the current packet
  logic [`NOC_LEN_W-1:0] count;   // cycles held so far

  // the limit is reloaded by every head flit, even mid-hold
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flitId == nocArbPkg::HEAD)
    begin
      limit <= length;
    end
  end

  // run drops as soon as count reaches limit, so count never wraps
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  assign timesUp = (count == limit);  // holder gets limit+1 cycles at most

endmodule

/* portArbiter.sv */
`include "nocArb_consts.svh"

module portArbiter
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lReq,
  input  logic                  nReq,
  input  logic                  eReq,
  input  logic                  wReq,
  input  logic                  sReq,
  input  logic                  lTimesUp,
  input  logic                  nTimesUp,
  input  logic                  eTimesUp,
  input  logic                  wTimesUp,
  input  logic                  sTimesUp,
  output logic                  lRun,
  output logic                  nRun,
  output logic                  eRun,
  output logic                  wRun,
  output logic                  sRun,
  output logic [`NOC_PORTS-1:0] grant
);

  nocArbPkg::arbState state;
  nocArbPkg::arbState nextState;

  logic [`NOC_PORTS-1:0] reqVec;   // index 0 is L, index 4 is S
  logic [`NOC_PORTS-1:0] upVec;
  logic [`NOC_PORTS-1:0] runVec;

  assign reqVec = {sReq, wReq, eReq, nReq, lReq};
  assign upVec  = {sTimesUp, wTimesUp, eTimesUp, nTimesUp, lTimesUp};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // state that grants port idx, the bit above IDLE's
  function automatic nocArbPkg::arbState portState(input int unsigned idx);
    portState = nocArbPkg::arbState'(6'b000010 << idx);
  endfunction

  // first requester among span ports starting at first, wrapping S back to L
  function automatic nocArbPkg::arbState pickNext(
    input logic [`NOC_PORTS-1:0] req,
    input int unsigned           first,
    input int unsigned           span
  );
    logic [2*`NOC_PORTS-1:0] wrapped;
    nocArbPkg::arbState      found;
    logic                    hit;
    int unsigned             idx;
    wrapped = {req, req};
    found = nocArbPkg::IDLE;
    hit = 1'b0;
    for (int unsigned i = 0; i < `NOC_PORTS; i++)
    begin
      idx = first + i;
      if (!hit && (i < span) && wrapped[idx])
      begin
        if (idx >= `NOC_PORTS)
        begin
          idx = idx - `NOC_PORTS;
        end
        found = portState(idx);
        hit = 1'b1;
      end
    end
    pickNext = found;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state register and next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocArbPkg::IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    int unsigned holder;
    logic        idle;
    holder = 0;
    idle = 1'b0;
    nextState = nocArbPkg::IDLE;
    runVec = '0;

    case (state)
      nocArbPkg::GRANT_L: holder = 0;
      nocArbPkg::GRANT_N: holder = 1;
      nocArbPkg::GRANT_E: holder = 2;
      nocArbPkg::GRANT_W: holder = 3;
      nocArbPkg::GRANT_S: holder = 4;
      default:            idle = 1'b1;  // IDLE and any illegal encoding
    endcase

    if (idle)
    begin
      nextState = pickNext(reqVec, 0, `NOC_PORTS);  // plain L N E W S priority
    end
    else if (reqVec[holder] && !upVec[holder])
    begin
      runVec[holder] = 1'b1;
      nextState = state;
    end
    else
    begin
      // the holder itself is left out, a timed-out port goes through IDLE
      nextState = pickNext(reqVec, holder + 1, `NOC_PORTS - 1);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign grant = state[`NOC_PORTS:1];  // IDLE bit drops off, giving zero

  assign lRun = runVec[0];
  assign nRun = runVec[1];
  assign eRun = runVec[2];
  assign wRun = runVec[3];
  assign sRun = runVec[4];

endmodule

/* flitCrossbar.sv */
`include "nocArb_consts.svh"

module flitCrossbar
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`NOC_PORTS-1:0]  grant,
  input  logic                   lReq,
  input  logic                   nReq,
  input  logic                   eReq,
  input  logic                   wReq,
  input  logic                   sReq,
  input  logic [`NOC_FLIT_W-1:0] lFlit,
  input  logic [`NOC_FLIT_W-1:0] nFlit,
  input  logic [`NOC_FLIT_W-1:0] eFlit,
  input  logic [`NOC_FLIT_W-1:0] wFlit,
  input  logic [`NOC_FLIT_W-1:0] sFlit,
  output logic [`NOC_FLIT_W-1:0] outFlit,
  output logic                   outValid
);

  logic [`NOC_PORTS-1:0]  reqVec;
  logic [`NOC_FLIT_W-1:0] flits [`NOC_PORTS];
  logic [`NOC_FLIT_W-1:0] selFlit;
  logic                   selValid;

  assign reqVec = {sReq, wReq, eReq, nReq, lReq};

  assign flits[0] = lFlit;
  assign flits[1] = nFlit;
  assign flits[2] = eFlit;
  assign flits[3] = wFlit;
  assign flits[4] = sFlit;

  // grant is one-hot or zero, so an and-or tree is enough
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      selFlit = selFlit | (flits[i] & {`NOC_FLIT_W{grant[i]}});
    end
  end

  assign selValid = |(grant & reqVec);  // granted port must still be asking

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selValid;
    end
  end

  // last forwarded flit stays on the output between packets
  always_ff @(posedge clk)
  begin
    if (selValid)
    begin
      outFlit <= selFlit;
    end
  end

endmodule

/* nocOutPort.sv */
`include "nocArb_consts.svh"

module nocOutPort
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   lReq,
  input  nocArbPkg::flitKind     lFlitId,
  input  logic [`NOC_LEN_W-1:0]  lLength,
  input  logic [`NOC_FLIT_W-1:0] lFlit,
  input  logic                   nReq,
  input  nocArbPkg::flitKind     nFlitId,
  input  logic [`NOC_LEN_W-1:0]  nLength,
  input  logic [`NOC_FLIT_W-1:0] nFlit,
  input  logic                   eReq,
  input  nocArbPkg::flitKind     eFlitId,
  input  logic [`NOC_LEN_W-1:0]  eLength,
  input  logic [`NOC_FLIT_W-1:0] eFlit,
  input  logic                   wReq,
  input  nocArbPkg::flitKind     wFlitId,
  input  logic [`NOC_LEN_W-1:0]  wLength,
  input  logic [`NOC_FLIT_W-1:0] wFlit,
  input  logic                   sReq,
  input  nocArbPkg::flitKind     sFlitId,
  input  logic [`NOC_LEN_W-1:0]  sLength,
  input  logic [`NOC_FLIT_W-1:0] sFlit,
  output logic [`NOC_PORTS-1:0]  grant,
  output logic [`NOC_FLIT_W-1:0] outFlit,
  output logic                   outValid
);

  logic lRun, nRun, eRun, wRun, sRun;
  logic lTimesUp, nTimesUp, eTimesUp, wTimesUp, sTimesUp;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one packet timer per input port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  packetTimer lTimer (.clk(clk), .rst(rst), .flitId(lFlitId), .length(lLength),
                      .run(lRun), .timesUp(lTimesUp));
  packetTimer nTimer (.clk(clk), .rst(rst), .flitId(nFlitId), .length(nLength),
                      .run(nRun), .timesUp(nTimesUp));
  packetTimer eTimer (.clk(clk), .rst(rst), .flitId(eFlitId), .length(eLength),
                      .run(eRun), .timesUp(eTimesUp));
  packetTimer wTimer (.clk(clk), .rst(rst), .flitId(wFlitId), .length(wLength),
                      .run(wRun), .timesUp(wTimesUp));
  packetTimer sTimer (.clk(clk), .rst(rst), .flitId(sFlitId), .length(sLength),
                      .run(sRun), .timesUp(sTimesUp));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // allocation and forwarding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  portArbiter arbiter
  (
    .clk(clk),
    .rst(rst),
    .lReq(lReq),
    .nReq(nReq),
    .eReq(eReq),
    .wReq(wReq),
    .sReq(sReq),
    .lTimesUp(lTimesUp),
    .nTimesUp(nTimesUp),
    .eTimesUp(eTimesUp),
    .wTimesUp(wTimesUp),
    .sTimesUp(sTimesUp),
    .lRun(lRun),
    .nRun(nRun),
    .eRun(eRun),
    .wRun(wRun),
    .sRun(sRun),
    .grant(grant)
  );

  flitCrossbar crossbar
  (
    .clk(clk),
    .rst(rst),
    .grant(grant),         // same registered grant seen at the top output
    .lReq(lReq),
    .nReq(nReq),
    .eReq(eReq),
    .wReq(wReq),
    .sReq(sReq),
    .lFlit(lFlit),
    .nFlit(nFlit),
    .eFlit(eFlit),
    .wFlit(wFlit),
    .sFlit(sFlit),
    .outFlit(outFlit),
    .outValid(outValid)
  );

endmodule

/* nocArb_assertions.sv */
`include "nocArb_consts.svh"

module nocArbChecks
(
  input logic                  clk,
  input logic                  rst,
  input logic                  lReq, nReq, eReq, wReq, sReq,
  input nocArbPkg::flitKind    lFlitId, nFlitId, eFlitId, wFlitId, sFlitId,
  input logic [`NOC_LEN_W-1:0] lLength, nLength, eLength, wLength, sLength,
  input logic [`NOC_PORTS-1:0] grant,
  input logic                  outValid
);

  timeunit 1ns;
  timeprecision 1ps;

  int failCount = 0;

  logic [`NOC_PORTS-1:0] reqVec;
  logic [`NOC_PORTS-1:0] prevGrant;
  logic [`NOC_LEN_W-1:0] limits [`NOC_PORTS];
  int unsigned           heldFor;    // samples in a row that showed prevGrant
  int unsigned           holdLimit;

  assign reqVec = {sReq, wReq, eReq, nReq, lReq};

  function automatic void recordFailure(input string what);
    $error("%s", what);
    failCount++;
  endfunction

  // next holder, scanning the ports after the current one and wrapping S to L
  function automatic logic [`NOC_PORTS-1:0] firstAfter(
    input logic [`NOC_PORTS-1:0] held,
    input logic [`NOC_PORTS-1:0] req
  );
    logic [`NOC_PORTS-1:0] found;
    int                    start;
    int                    idx;
    found = '0;
    start = 0;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      if (held[i])
      begin
        start = i + 1;
      end
    end
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      idx = (start + i) % `NOC_PORTS;
      if (found == '0 && req[idx] && !held[idx])
      begin
        found[idx] = 1'b1;
      end
    end
    return found;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // hold tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limits <= '{default: '0};
      prevGrant <= '0;
      heldFor <= 0;
    end
    else
    begin
      if (lFlitId == nocArbPkg::HEAD)
        limits[0] <= lLength;
      if (nFlitId == nocArbPkg::HEAD)
        limits[1] <= nLength;
      if (eFlitId == nocArbPkg::HEAD)
        limits[2] <= eLength;
      if (wFlitId == nocArbPkg::HEAD)
        limits[3] <= wLength;
      if (sFlitId == nocArbPkg::HEAD)
        limits[4] <= sLength;
      heldFor <= (grant == prevGrant) ? heldFor + 1 : 1;
      prevGrant <= grant;
    end
  end

  always_comb
  begin
    holdLimit = 0;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      if (grant[i])
      begin
        holdLimit = limits[i];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  resetQuiet: assert property (@(posedge clk) rst |=> (grant == '0) && !outValid)
    else recordFailure("grant or outValid active in or right after reset");

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else recordFailure("grant has more than one bit set");

  grantWasAsked: assert property (@(posedge clk) disable iff (rst)
    (grant & ~$past(reqVec)) == '0)
    else recordFailure("grant given to a port that was not requesting");

  rotationOrder: assert property (@(posedge clk) disable iff (rst)
    (grant != $past(grant)) |-> grant == firstAfter($past(grant), $past(reqVec)))
    else recordFailure("grant moved to the wrong port");

  holdBounded: assert property (@(posedge clk) disable iff (rst)
    (grant != '0 && grant == prevGrant) |-> heldFor <= holdLimit)
    else recordFailure("grant held past the packet length");

  earlyRelease: assert property (@(posedge clk) disable iff (rst)
    (grant != '0 && (grant & reqVec) == '0) |=> grant != $past(grant))
    else recordFailure("holder kept the grant after dropping its request");

endmodule

bind nocOutPort nocArbChecks checks (.*);

/* nocArbTb.sv */
`include "nocArb_consts.svh"

module nocArbTb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                   clk;
  logic                   rst;
  logic                   req    [`NOC_PORTS];
  nocArbPkg::flitKind     flitId [`NOC_PORTS];
  logic [`NOC_LEN_W-1:0]  length [`NOC_PORTS];
  logic [`NOC_FLIT_W-1:0] flit   [`NOC_PORTS];
  logic [`NOC_PORTS-1:0]  grant;
  logic [`NOC_FLIT_W-1:0] outFlit;
  logic                   outValid;

  logic [`NOC_PORTS-1:0]  modelGrant;
  logic                   modelValid;
  logic [`NOC_FLIT_W-1:0] modelFlit;
  int unsigned            modelCount [`NOC_PORTS];
  int unsigned            modelLimit [`NOC_PORTS];

  logic [31:0] rngState = 32'h3574;
  int          errors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;

  nocOutPort UUT
  (
    .clk(clk), .rst(rst),
    .lReq(req[0]), .lFlitId(flitId[0]), .lLength(length[0]), .lFlit(flit[0]),
    .nReq(req[1]), .nFlitId(flitId[1]), .nLength(length[1]), .nFlit(flit[1]),
    .eReq(req[2]), .eFlitId(flitId[2]), .eLength(length[2]), .eFlit(flit[2]),
    .wReq(req[3]), .wFlitId(flitId[3]), .wLength(length[3]), .wFlit(flit[3]),
    .sReq(req[4]), .sFlitId(flitId[4]), .sLength(length[4]), .sFlit(flit[4]),
    .grant(grant), .outFlit(outFlit), .outValid(outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string stateName(input logic [`NOC_PORTS-1:0] g);
    nocArbPkg::arbState s;
    s = nocArbPkg::arbState'({g, g == '0});
    return s.name();
  endfunction

  function automatic int problemCount();
    return errors + UUT.checks.failCount;
  endfunction

  // the registered outputs have not moved yet when the rising edge is seen here
  task automatic compareOutputs();
    if (grant !== modelGrant)
    begin
      $display("** Error: grant expected 0x%h got 0x%h", modelGrant, grant);
      errors++;
    end
    if (outValid !== modelValid)
    begin
      $display("** Error: outValid expected 0x%h got 0x%h", modelValid, outValid);
      errors++;
    end
    if (modelValid && outFlit !== modelFlit)
    begin
      $display("** Error: outFlit expected 0x%h got 0x%h", modelFlit, outFlit);
      errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model stepped on each rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk)
  begin
    logic [`NOC_PORTS-1:0] r;
    logic [`NOC_PORTS-1:0] nxt;
    int                    h;
    int                    idx;
    for (int i = 0; i < `NOC_PORTS; i++)
      r[i] = req[i];
    if (rst)
    begin
      modelGrant = '0;
      modelValid = 1'b0;
      modelCount = '{default: 0};
      modelLimit = '{default: 0};
    end
    else
    begin
      compareOutputs();
      modelValid = |(modelGrant & r);
      nxt = '0;
      h = -1;
      for (int i = 0; i < `NOC_PORTS; i++)
      begin
        if (modelGrant[i] && r[i])
          modelFlit = flit[i];
        if (modelGrant[i])
          h = i;
      end
      if (h >= 0 && r[h] && modelCount[h] != modelLimit[h])
        nxt = modelGrant;  // hold continues
      else
      begin
        for (int k = 1; k < ((h < 0) ? 6 : 5); k++)
        begin
          idx = (h + k) % `NOC_PORTS;
          if (nxt == '0 && r[idx])
            nxt[idx] = 1'b1;
        end
      end
      for (int i = 0; i < `NOC_PORTS; i++)
      begin
        modelCount[i] = (h == i && nxt == modelGrant) ? modelCount[i] + 1 : 0;
        if (flitId[i] == nocArbPkg::HEAD)
          modelLimit[i] = length[i];
      end
      modelGrant = nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic step(input logic [`NOC_PORTS-1:0] reqs);
    @(negedge clk);
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      rngState = xorshift(rngState);
      flit[i] = rngState;
      req[i] = reqs[i];
      flitId[i] = nocArbPkg::BODY;
    end
  endtask

  task automatic waitGrant(input int idx, input logic [`NOC_PORTS-1:0] reqs, input int maxCycles);
    int n;
    n = 0;
    while (grant[idx] !== 1'b1 && n < maxCycles)
    begin
      step(reqs);
      n++;
    end
    if (grant[idx] !== 1'b1)
    begin
      $display("timeout: %s not reached within %0d cycles", stateName(5'b1 << idx), maxCycles);
      errors++;
    end
  endtask

  task automatic waitIdle(input int maxCycles);
    int n;
    n = 0;
    while (grant !== '0 && n < maxCycles)
    begin
      step('0);
      n++;
    end
    if (grant !== '0)
    begin
      $display("timeout: grant still at %s after %0d cycles", stateName(grant), maxCycles);
      errors++;
    end
  endtask

  task automatic finishTest(input string name, input int mark);
    testsRun++;
    if (problemCount() == mark)
      $display("test %s: ok", name);
    else
    begin
      testsFailed++;
      $display("test %s: %0d errors", name, problemCount() - mark);
    end
  endtask

  initial
  begin
    int mark;
    int held;
    int k;
    int lens [3];
    lens = '{0, 3, 10};
    rst = 1'b1;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      req[i] = 1'b1;  // every port asks during reset, which must still win
      flitId[i] = nocArbPkg::NONE;
      length[i] = '0;
      flit[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < `NOC_PORTS; i++)
      req[i] = 1'b0;
    mark = problemCount();
    step('0);
    step('0);
    finishTest("reset", mark);

    // all limits are zero here, so every holder gives up after one cycle
    mark = problemCount();
    for (int p = 0; p < 6; p++)
      waitGrant(p % `NOC_PORTS, 5'b11111, 8);
    waitIdle(8);
    waitGrant(1, 5'b10010, 8);
    waitGrant(4, 5'b10010, 4);
    waitGrant(1, 5'b10010, 4);
    waitIdle(8);
    finishTest("rotation", mark);

    foreach (lens[j])
    begin
      mark = problemCount();
      waitIdle(8);
      step('0);
      flitId[1] = nocArbPkg::HEAD;
      length[1] = lens[j];
      waitGrant(1, 5'b01010, 8);
      held = 0;
      while (grant[1] === 1'b1 && held < 40)
      begin
        held++;
        step(5'b01010);
      end
      if (held >= 40)
      begin
        $display("timeout: North kept the grant for 40 cycles");
        errors++;
      end
      else if (held != lens[j] + 1)
      begin
        $display("** Error: nHoldCycles expected 0x%h got 0x%h", lens[j] + 1, held);
        errors++;
      end
      waitGrant(3, 5'b01010, 4);
      waitIdle(8);
      finishTest($sformatf("timeout len %0d", lens[j]), mark);
    end

    mark = problemCount();
    step('0);
    flitId[2] = nocArbPkg::HEAD;
    length[2] = 12'd10;
    flitId[4] = nocArbPkg::HEAD;
    length[4] = 12'd10;
    waitGrant(2, 5'b10100, 8);
    step(5'b10100);
    step(5'b10100);
    step(5'b10000);  // East lets go well before its limit
    waitGrant(4, 5'b10000, 3);
    step(5'b10000);
    step('0);
    waitIdle(3);
    finishTest("early release", mark);

    mark = problemCount();
    for (int c = 0; c < 300; c++)
    begin
      rngState = xorshift(rngState);
      step(rngState[4:0]);
      k = rngState[14:12] % `NOC_PORTS;
      // new lengths only go to idle ports so a hold never sees its limit shrink
      if (rngState[7:5] == 3'd0 && !req[k])
      begin
        flitId[k] = nocArbPkg::HEAD;
        length[k] = rngState[11:8];
      end
    end
    waitIdle(4);
    finishTest("random forwarding", mark);

    $display("tests %0d, failed %0d, model errors %0d, assertion failures %0d",
             testsRun, testsFailed, errors, UUT.checks.failCount);
    if (testsFailed == 0 && problemCount() == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* nocArb.f */
+incdir+.
nocArbPkg.sv
packetTimer.sv
portArbiter.sv
flitCrossbar.sv
nocOutPort.sv
nocArb_assertions.sv
nocArbTb.sv
